//--- Bender.yml
package:
  name: gambit_decode

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/gambitPkg.sv
      - source/instrDecoder.sv
      - source/branchTargetCalc.sv
      - source/decodeStage.sv
      - source/gambitDecode.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_gambitDecode.sv

//--- source/branchTargetCalc.sv
`include "gambit_config.svh"

module branchTargetCalc (
	input logic [`PC_W-1:0] pc,
	input logic [`INSTR_W-1:0] constVal,
	input logic isBranch,
	output logic [`PC_W-1:0] branchTarget
);

	// ==========================================================
	// target adder
	// ==========================================================

	// amount added to the pc
	logic [`PC_W-1:0] offset;

	// branches jump by the displacement
	// everything else falls through to the next instruction
	always_comb
	begin
		if (isBranch)
		begin
			// upper constant bits drop out, sum wraps at PC_W
			offset = constVal[`PC_W-1:0];
		end
		else
		begin
			offset = `PC_W'(1);
		end
	end

	// one shared adder for both cases
	// the fall-through value lets later stages check a wrong prediction
	assign branchTarget = pc + offset;

endmodule

//--- source/decodeStage.sv
`include "gambit_config.svh"

module decodeStage (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic instrValid,
	input gambitPkg::instrU instr,
	input logic [`PC_W-1:0] pc,
	input logic predictTaken,
	output logic decValid,
	output gambitPkg::decodeBusS decOut
);
	import gambitPkg::*;

	// raw decoder output, no pc yet
	decodeBusS decBus;
	// decoder output with pc and target folded in
	decodeBusS fullBus;
	logic [`PC_W-1:0] target;
	// strobe that survives a flush
	logic accept;

	instrDecoder i_instrDecoder (
		.instr(instr),
		.predictTaken(predictTaken),
		.bus(decBus)
	);

	branchTargetCalc i_branchTargetCalc (
		.pc(pc),
		.constVal(decBus.constVal),
		.isBranch(decBus.isBranch),
		.branchTarget(target)
	);

	always_comb
	begin
		fullBus = decBus;
		fullBus.pc = pc;
		fullBus.branchTarget = target;
	end

	// flush wins over a new strobe
	assign accept = instrValid && !flush;

	// ==========================================================
	// output register
	// ==========================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			decValid <= 1'b0;
			decOut <= '0;
		end
		else
		begin
			// valid for one cycle per accepted strobe
			decValid <= accept;
			// data holds between strobes
			if (accept)
				decOut <= fullBus;
		end
	end

endmodule

//--- source/gambitDecode.sv
`include "gambit_config.svh"

module gambitDecode (
	input logic clk,
	input logic rst,
	// kills the instruction in flight
	input logic flush,
	// fetch side, one word per strobe
	input logic instrValid,
	input gambitPkg::instrU instr,
	input logic [`PC_W-1:0] pc,
	input logic predictTaken,
	// decoded result, one cycle later
	output logic decValid,
	output gambitPkg::decodeBusS decOut
);

	// ==========================================================
	// decode pipeline stage
	// ==========================================================

	decodeStage i_decodeStage (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.predictTaken(predictTaken),
		.decValid(decValid),
		.decOut(decOut)
	);

endmodule

//--- source/gambitPkg.sv
`include "gambit_config.svh"

package gambitPkg;

	// ==========================================================
	// opcode and memory size encodings
	// ==========================================================

	// one value per major opcode, NOP sits at zero
	typedef enum logic [`OPCODE_W-1:0] {
		NOP = '0,
		MTX, MFX,
		ADDIS, ANDIS, ORIS,
		PERM_3R,
		CSR,
		// alu ops with register, 22 bit and 35 bit operand forms
		ADD_3R, ADD_RI22, ADD_RI35,
		SUB_3R, SUB_RI22, SUB_RI35,
		MUL_3R, MUL_RI22, MUL_RI35,
		AND_3R, AND_RI22, AND_RI35,
		OR_3R, OR_RI22, OR_RI35,
		EOR_3R, EOR_RI22, EOR_RI35,
		BIT_3R, BIT_RI22, BIT_RI35,
		CMP_3R, CMP_RI22, CMP_RI35,
		CMPU_3R, CMPU_RI22, CMPU_RI35,
		// shifts and rotates exist only as 3r
		ASL_3R, ASR_3R, ROL_3R, ROR_3R, LSR_3R,
		// loads and stores, displacement in three sizes
		LD_D8, LD_D22, LD_D35,
		ST_D8, ST_D22, ST_D35,
		LDB_D8, LDB_D22, LDB_D35,
		STB_D8, STB_D22, STB_D35,
		// flow control
		JAL, JAL_RN,
		BRANCH0, BRANCH1
	} opcodeE;

	// access width of a memory op
	typedef enum logic [2:0] {
		SZ_BYTE = 3'd0,
		SZ_WORD = 3'd1
	} memSizeE;

	// ==========================================================
	// instruction word views
	// ==========================================================

	// register form, 8 bit constant between ra and rb
	typedef struct packed {
		logic [`REG_SPARE_W-1:0] spare;
		logic [`REG_W-1:0] rb;
		logic [`CONST8_W-1:0] const8;
		logic [`REG_W-1:0] ra;
		logic [`REG_W-1:0] rt;
		opcodeE opcode;
	} instrRegS;

	// immediate form, the 22 bit constant is the low end of const35
	typedef struct packed {
		logic [`CONST35_W-1:0] const35;
		logic [`REG_W-1:0] ra;
		logic [`REG_W-1:0] rt;
		opcodeE opcode;
	} instrImmS;

	// same 52 bits, read either way
	typedef union packed {
		instrRegS regForm;
		instrImmS immForm;
	} instrU;

	// ==========================================================
	// decoded bundle handed to rename
	// ==========================================================

	typedef struct packed {
		opcodeE opcode;
		logic [`REG_W-1:0] rt;
		logic [`REG_W-1:0] ra;
		logic [`REG_W-1:0] rb;
		// sign extended to the full word
		logic [`INSTR_W-1:0] constVal;
		logic isAlu;
		logic isCmp;
		logic isMem;
		logic isLoad;
		logic isStore;
		logic isFlowCtrl;
		logic isBranch;
		logic isJal;
		logic rfWrite;
		memSizeE memSize;
		logic predictTaken;
		logic [`PC_W-1:0] pc;
		logic [`PC_W-1:0] branchTarget;
	} decodeBusS;

endpackage

//--- source/gambit_config.svh
`ifndef GAMBIT_CONFIG_SVH
`define GAMBIT_CONFIG_SVH

// ==========================================================
// datapath widths
// ==========================================================

// full instruction word
`define INSTR_W 52

// opcode field at the bottom of every instruction
`define OPCODE_W 7

// register specifier for rt, ra and rb
`define REG_W 5

// fetch program counter, counts whole instructions
`define PC_W 32

// ==========================================================
// immediate forms
// ==========================================================

`define CONST8_W 8
`define CONST22_W 22
`define CONST35_W 35

// upper bits left idle by the register form
`define REG_SPARE_W (`INSTR_W - `OPCODE_W - 3 * `REG_W - `CONST8_W)

`endif

//--- source/instrDecoder.sv
`include "gambit_config.svh"

module instrDecoder (
	input gambitPkg::instrU instr,
	input logic predictTaken,
	output gambitPkg::decodeBusS bus
);
	import gambitPkg::*;

	// opcode of the word being decoded
	opcodeE op;
	// constant bits, widest view
	logic [`CONST35_W-1:0] immBits;

	assign op = instr.regForm.opcode;
	assign immBits = instr.immForm.const35;

	// ==========================================================
	// opcode classification
	// ==========================================================

	function automatic logic opIsAlu(input opcodeE opc);
		case (opc)
			MTX, MFX, ADDIS, ANDIS, ORIS, PERM_3R, CSR,
			ADD_3R, ADD_RI22, ADD_RI35, SUB_3R, SUB_RI22, SUB_RI35,
			MUL_3R, MUL_RI22, MUL_RI35, AND_3R, AND_RI22, AND_RI35,
			OR_3R, OR_RI22, OR_RI35, EOR_3R, EOR_RI22, EOR_RI35,
			ASL_3R, ASR_3R, ROL_3R, ROR_3R, LSR_3R,
			BIT_3R, BIT_RI22, BIT_RI35, CMP_3R, CMP_RI22, CMP_RI35,
			CMPU_3R, CMPU_RI22, CMPU_RI35:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// 8 bit constant, all 3r ops and short displacements
	function automatic logic opHasConst8(input opcodeE opc);
		case (opc)
			ADD_3R, SUB_3R, MUL_3R, AND_3R, OR_3R, EOR_3R,
			BIT_3R, CMP_3R, CMPU_3R, PERM_3R,
			ASL_3R, ASR_3R, ROL_3R, ROR_3R, LSR_3R,
			LD_D8, ST_D8, LDB_D8, STB_D8:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic opHasConst22(input opcodeE opc);
		case (opc)
			ADD_RI22, SUB_RI22, MUL_RI22, AND_RI22, OR_RI22, EOR_RI22,
			BIT_RI22, CMP_RI22, CMPU_RI22,
			LD_D22, ST_D22, LDB_D22, STB_D22:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic opIsCmp(input opcodeE opc);
		case (opc)
			CMP_3R, CMP_RI22, CMP_RI35, CMPU_3R, CMPU_RI22, CMPU_RI35:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic opIsLoad(input opcodeE opc);
		case (opc)
			LD_D8, LD_D22, LD_D35, LDB_D8, LDB_D22, LDB_D35:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic opIsStore(input opcodeE opc);
		case (opc)
			ST_D8, ST_D22, ST_D35, STB_D8, STB_D22, STB_D35:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// any load or store goes to the memory queue
	function automatic logic opIsMem(input opcodeE opc);
		return opIsLoad(opc) || opIsStore(opc);
	endfunction

	function automatic memSizeE opMemSize(input opcodeE opc);
		case (opc)
			LDB_D8, LDB_D22, LDB_D35, STB_D8, STB_D22, STB_D35:
				return SZ_BYTE;
			default:
				return SZ_WORD;
		endcase
	endfunction

	function automatic logic opIsFlowCtrl(input opcodeE opc);
		case (opc)
			JAL, JAL_RN, BRANCH0, BRANCH1:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// predictable branches only, jumps resolve elsewhere
	function automatic logic opIsBranch(input opcodeE opc);
		case (opc)
			BRANCH0, BRANCH1:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// jump and link is known from the opcode alone
	function automatic logic opIsJal(input opcodeE opc);
		case (opc)
			JAL, JAL_RN:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// nop, branches and stores leave the register file alone
	function automatic logic opRfWrite(input opcodeE opc);
		case (opc)
			NOP, BRANCH0, BRANCH1,
			ST_D8, ST_D22, ST_D35, STB_D8, STB_D22, STB_D35:
				return 1'b0;
			default:
				return 1'b1;
		endcase
	endfunction

	// ==========================================================
	// bundle assembly
	// ==========================================================

	always_comb
	begin
		// pc and branchTarget stay zero here, merged in by the stage
		bus = '0;
		bus.opcode = op;
		bus.rt = instr.regForm.rt;
		bus.ra = instr.regForm.ra;
		bus.rb = instr.regForm.rb;
		// pick the constant width, then sign extend
		if (opHasConst8(op))
			bus.constVal = {{(`INSTR_W - `CONST8_W){immBits[`CONST8_W-1]}},
				immBits[`CONST8_W-1:0]};
		else if (opHasConst22(op))
			bus.constVal = {{(`INSTR_W - `CONST22_W){immBits[`CONST22_W-1]}},
				immBits[`CONST22_W-1:0]};
		else
			bus.constVal = {{(`INSTR_W - `CONST35_W){immBits[`CONST35_W-1]}}, immBits};
		bus.isAlu = opIsAlu(op);
		bus.isCmp = opIsCmp(op);
		bus.isMem = opIsMem(op);
		bus.isLoad = opIsLoad(op);
		bus.isStore = opIsStore(op);
		bus.isFlowCtrl = opIsFlowCtrl(op);
		bus.isBranch = opIsBranch(op);
		bus.isJal = opIsJal(op);
		bus.rfWrite = opRfWrite(op);
		bus.memSize = opMemSize(op);
		// prediction from fetch rides along untouched
		bus.predictTaken = predictTaken;
	end

endmodule

//--- src.f
+incdir+source
source/gambitPkg.sv
source/instrDecoder.sv
source/branchTargetCalc.sv
source/decodeStage.sv
source/gambitDecode.sv
testbench/tb_gambitDecode.sv

//--- testbench/tb_gambitDecode.sv
`include "gambit_config.svh"

module tb_gambitDecode;
	import gambitPkg::*;

	// ==========================================================
	// stimulus table
	// ==========================================================

	// flags are isAlu, isCmp, isMem, isLoad, isStore, isFlowCtrl, isBranch, isJal, rfWrite
	// upper holds word bits 51:17, so rb is upper[12:8] and const8 is upper[7:0]
	typedef struct packed {
		opcodeE opcode;
		logic [`REG_W-1:0] rt;
		logic [`REG_W-1:0] ra;
		logic [`CONST35_W-1:0] upper;
		logic predictTaken;
		logic [8:0] flags;
		memSizeE memSize;
		logic [`INSTR_W-1:0] constVal;
	} rowS;

	localparam int numRows = 17;

	localparam rowS rowTable [0:numRows-1] = '{
		// alu, 3r form, const8 positive then negative
		'{ADD_3R, 5'd3, 5'd4, 35'h705, 1'b0, 9'h101, SZ_WORD, 52'h5},
		'{SUB_3R, 5'd1, 5'd2, 35'h2F0, 1'b0, 9'h101, SZ_WORD, 52'hF_FFFF_FFFF_FFF0},
		// alu, 22 bit constant, junk above bit 21 must drop out
		'{ADD_RI22, 5'd6, 5'd7, 35'h12345, 1'b0, 9'h101, SZ_WORD, 52'h1_2345},
		'{AND_RI22, 5'd8, 5'd9, 35'h7_0020_0001, 1'b0, 9'h101, SZ_WORD, 52'hF_FFFF_FFE0_0001},
		// alu, 35 bit constant
		'{OR_RI35, 5'd10, 5'd11, 35'h1_2345_6789, 1'b1, 9'h101, SZ_WORD, 52'h1_2345_6789},
		'{EOR_RI35, 5'd12, 5'd13, 35'h4_0000_0010, 1'b0, 9'h101, SZ_WORD, 52'hF_FFFC_0000_0010},
		'{CMP_RI22, 5'd14, 5'd15, 35'h7F, 1'b0, 9'h181, SZ_WORD, 52'h7F},
		// loads and stores in both sizes
		'{LD_D8, 5'd16, 5'd17, 35'h980, 1'b0, 9'h061, SZ_WORD, 52'hF_FFFF_FFFF_FF80},
		'{LDB_D22, 5'd18, 5'd19, 35'h1_0000, 1'b0, 9'h061, SZ_BYTE, 52'h1_0000},
		'{ST_D35, 5'd20, 5'd21, 35'h100, 1'b0, 9'h050, SZ_WORD, 52'h100},
		'{STB_D8, 5'd22, 5'd23, 35'h1F7F, 1'b1, 9'h050, SZ_BYTE, 52'h7F},
		// flow control
		'{JAL, 5'd24, 5'd25, 35'h40, 1'b0, 9'h00B, SZ_WORD, 52'h40},
		'{BRANCH0, 5'd26, 5'd27, 35'h20, 1'b1, 9'h00C, SZ_WORD, 52'h20},
		'{BRANCH1, 5'd28, 5'd29, 35'h7_FFFF_FFF0, 1'b1, 9'h00C, SZ_WORD, 52'hF_FFFF_FFFF_FFF0},
		'{NOP, 5'd0, 5'd0, 35'h0, 1'b0, 9'h000, SZ_WORD, 52'h0},
		'{CSR, 5'd30, 5'd31, 35'h1234, 1'b0, 9'h101, SZ_WORD, 52'h1234},
		// permute is a 3r form as well, so const8
		'{PERM_3R, 5'd2, 5'd5, 35'h3A81, 1'b1, 9'h101, SZ_WORD, 52'hF_FFFF_FFFF_FF81}
	};

	logic clk;
	logic rst;
	logic flush;
	logic instrValid;
	instrU instr;
	logic [`PC_W-1:0] pc;
	logic predictTaken;
	logic decValid;
	decodeBusS decOut;

	int errCount = 0;
	int timeoutCount = 0;

	gambitDecode i_dut (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.predictTaken(predictTaken),
		.decValid(decValid),
		.decOut(decOut)
	);

	always #4 clk = ~clk;

	// ==========================================================
	// expected values and stimulus helpers
	// ==========================================================

	function automatic instrU buildInstr(input rowS r);
		instrU w;
		w.immForm.opcode = r.opcode;
		w.immForm.rt = r.rt;
		w.immForm.ra = r.ra;
		w.immForm.const35 = r.upper;
		return w;
	endfunction

	function automatic decodeBusS expectedBus(input rowS r, input logic [`PC_W-1:0] pcVal);
		decodeBusS b;
		b = '0;
		b.opcode = r.opcode;
		b.rt = r.rt;
		b.ra = r.ra;
		// rb lies just above const8 in the register view
		b.rb = r.upper[12:8];
		b.constVal = r.constVal;
		{b.isAlu, b.isCmp, b.isMem, b.isLoad, b.isStore, b.isFlowCtrl, b.isBranch, b.isJal,
			b.rfWrite} = r.flags;
		b.memSize = r.memSize;
		b.predictTaken = r.predictTaken;
		b.pc = pcVal;
		return b;
	endfunction

	// branch jumps by the displacement, all else falls through
	function automatic logic [`PC_W-1:0] expectedTarget(input rowS r,
		input logic [`PC_W-1:0] pcVal);
		if (r.flags[2])
			return pcVal + r.constVal[`PC_W-1:0];
		return pcVal + `PC_W'(1);
	endfunction

	task automatic driveRow(input rowS r, input logic [`PC_W-1:0] pcVal);
		@(negedge clk);
		instrValid = 1'b1;
		instr = buildInstr(r);
		pc = pcVal;
		predictTaken = r.predictTaken;
	endtask

	// drops the strobe, then polls for decValid
	task automatic waitValid(input int row);
		int cycles;
		bit seen;
		seen = 0;
		cycles = 0;
		while (!seen && cycles < 5)
		begin
			@(negedge clk);
			instrValid = 1'b0;
			cycles++;
			seen = decValid;
		end
		if (!seen)
		begin
			$display("decValid never arrived for table row %0d", row);
			timeoutCount++;
		end
		else if (cycles != 1)
		begin
			$display("decValid for table row %0d came %0d cycles after the strobe", row, cycles);
			errCount++;
		end
	endtask

	// ==========================================================
	// compare tasks
	// ==========================================================

	task automatic compareField(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		if (expVal !== actVal)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expVal, actVal);
			errCount++;
		end
	endtask

	task automatic checkBus(input decodeBusS exp);
		compareField("decOut.opcode", exp.opcode, decOut.opcode);
		compareField("decOut.rt", exp.rt, decOut.rt);
		compareField("decOut.ra", exp.ra, decOut.ra);
		compareField("decOut.rb", exp.rb, decOut.rb);
		compareField("decOut.constVal", exp.constVal, decOut.constVal);
		compareField("decOut.isAlu", exp.isAlu, decOut.isAlu);
		compareField("decOut.isCmp", exp.isCmp, decOut.isCmp);
		compareField("decOut.isMem", exp.isMem, decOut.isMem);
		compareField("decOut.isLoad", exp.isLoad, decOut.isLoad);
		compareField("decOut.isStore", exp.isStore, decOut.isStore);
		compareField("decOut.isFlowCtrl", exp.isFlowCtrl, decOut.isFlowCtrl);
		compareField("decOut.isBranch", exp.isBranch, decOut.isBranch);
		compareField("decOut.isJal", exp.isJal, decOut.isJal);
		compareField("decOut.rfWrite", exp.rfWrite, decOut.rfWrite);
		compareField("decOut.memSize", exp.memSize, decOut.memSize);
		compareField("decOut.predictTaken", exp.predictTaken, decOut.predictTaken);
		compareField("decOut.pc", exp.pc, decOut.pc);
	endtask

	task automatic checkTarget(input logic [`PC_W-1:0] exp);
		compareField("decOut.branchTarget", exp, decOut.branchTarget);
	endtask

	task automatic checkValid(input logic exp);
		compareField("decValid", exp, decValid);
	endtask

	// ==========================================================
	// test sequence
	// ==========================================================

	initial
	begin
		int i;
		logic [`PC_W-1:0] pcVal;
		decodeBusS lastBus;
		logic [`PC_W-1:0] lastTarget;
		void'($urandom(32'hcfae));
		clk = 1'b0;
		rst = 1'b1;
		flush = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		predictTaken = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		// outputs come out of reset cleared
		checkValid(1'b0);
		checkBus('0);
		checkTarget('0);

		// one strobe per row, result one cycle later
		for (i = 0; i < numRows; i++)
		begin
			pcVal = $urandom;
			driveRow(rowTable[i], pcVal);
			waitValid(i);
			checkValid(1'b1);
			checkBus(expectedBus(rowTable[i], pcVal));
			checkTarget(expectedTarget(rowTable[i], pcVal));
		end

		// back to back strobes, a result on every cycle
		for (i = 0; i < 4; i++)
		begin
			pcVal = $urandom;
			driveRow(rowTable[12 + i], pcVal);
			if (i > 0)
			begin
				checkValid(1'b1);
				checkBus(lastBus);
				checkTarget(lastTarget);
			end
			lastBus = expectedBus(rowTable[12 + i], pcVal);
			lastTarget = expectedTarget(rowTable[12 + i], pcVal);
		end
		@(negedge clk);
		instrValid = 1'b0;
		checkValid(1'b1);
		checkBus(lastBus);
		checkTarget(lastTarget);
		// idle cycle, valid drops and data holds
		@(negedge clk);
		checkValid(1'b0);
		checkBus(lastBus);
		checkTarget(lastTarget);

		// strobe killed by flush in the same cycle
		driveRow(rowTable[0], $urandom);
		flush = 1'b1;
		@(negedge clk);
		instrValid = 1'b0;
		flush = 1'b0;
		checkValid(1'b0);
		checkBus(lastBus);
		checkTarget(lastTarget);

		// reset again after traffic
		rst = 1'b1;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		checkValid(1'b0);
		checkBus('0);
		checkTarget('0);

		$display("errors: %0d mismatches, %0d timeouts", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
